/* Makefile */
TOP = concat_unit_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --timescale 1ns/1ps --top-module $(TOP) -f tb.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 ; cat sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/concat_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module concat_unit_tb;

  import concat_pkg::*;
  import concat_cfg_pkg::*;

  localparam int RAND_SEED     = 6880;
  localparam int FRAME_TIMEOUT = 3000;
  // Enough model slots for every pixel pushed in one run
  localparam int MODEL_SLOTS   = 512;

  logic                           clk = 1'b0;
  logic                           reset;
  cfg_write_t                     cfg;
  pixel_beat_t [NUM_BRANCHES-1:0] branch_in;
  pixel_beat_t                    out_beat;
  logic                           frame_done;

  // Mirror of each branch FIFO
  pixel_t       model_mem [NUM_BRANCHES][MODEL_SLOTS];
  int           model_head [NUM_BRANCHES];
  int           model_tail [NUM_BRANCHES];
  // Expected output order of the current frame
  pixel_t       exp_q [$];
  int           gap [NUM_BRANCHES][FIFO_DEPTH];
  int           push_count;
  // Configuration the DUT applies to the current frame
  int           active_len;
  branch_mask_t active_mask;
  int           errors;
  int           failed_tests;
  int           tests_run;
  int           frames_done;

  concat_unit concat_unit_inst (
    .clk        (clk),
    .reset      (reset),
    .cfg        (cfg),
    .branch_in  (branch_in),
    .out_beat   (out_beat),
    .frame_done (frame_done)
  );

  always #4 clk = ~clk;

  //////////////////////////////
  // Reporting
  //////////////////////////////

  function automatic void report_error(input string msg);
    $display("FAILED t=%0t: %s", $time, msg);
    errors++;
  endfunction

  function automatic void report_timeout(input string what);
    $display("Timeout at %0t: no %s within %0d cycles", $time, what, FRAME_TIMEOUT);
    errors++;
  endfunction

  function automatic void end_test(input string name, input int mark);
    tests_run++;
    if (errors != mark) failed_tests++;
    $display("Test %0d, %s: %0d errors", tests_run, name, errors - mark);
  endfunction

  // Written length 0 acts as 1 and anything above the depth as the depth
  function automatic int legal_len(input int written);
    if (written == 0) return 1;
    if (written > FIFO_DEPTH) return FIFO_DEPTH;
    return written;
  endfunction

  //////////////////////////////
  // Output checking
  //////////////////////////////

  // Output beats against the model on the falling edge
  always @(negedge clk) begin : check_output
    logic last_beat;
    if (!reset) begin
      last_beat = out_beat.valid && (exp_q.size() == 1);
      // Done pulse only with the final expected pixel
      assert (frame_done == last_beat) else
        report_error($sformatf("frame_done=%0b, last beat=%0b", frame_done, last_beat));
      if (frame_done) frames_done++;
      if (out_beat.valid) begin
        assert (exp_q.size() != 0) else
          report_error($sformatf("unexpected pixel %08h", out_beat.data));
        if (exp_q.size() != 0) begin
          assert (out_beat.data == exp_q[0]) else
            report_error($sformatf("pixel %08h, expected %08h", out_beat.data, exp_q[0]));
          void'(exp_q.pop_front());
        end
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // One-cycle register write starting at a drive slot
  task automatic write_cfg(input logic [CFG_ADDR_WIDTH-1:0] wr_addr,
                           input logic [CFG_DATA_WIDTH-1:0] wr_data);
    cfg = '{strobe: 1'b1, addr: wr_addr, data: wr_data};
    @(posedge clk);
    #1;
    cfg.strobe = 1'b0;
  endtask

  // Pushes this frame's pixels with the preset gaps
  task automatic drive_branch(input int b);
    for (int i = 0; i < push_count; i++) begin
      repeat (gap[b][i]) begin
        branch_in[b].valid = 1'b0;
        @(posedge clk);
        #1;
      end
      branch_in[b].valid = 1'b1;
      branch_in[b].data  = model_mem[b][model_tail[b] - push_count + i];
      @(posedge clk);
      #1;
    end
    branch_in[b].valid = 1'b0;
  endtask

  task automatic wait_first_beat();
    int cycles;
    cycles = 0;
    while (!out_beat.valid && cycles < FRAME_TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!out_beat.valid) report_timeout("first output pixel");
  endtask

  task automatic wait_frame_done(input int start_count);
    int cycles;
    cycles = 0;
    while (frames_done == start_count && cycles < FRAME_TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (frames_done == start_count) begin
      report_timeout("frame_done");
      exp_q.delete();
    end
  endtask

  // One frame that may stage the next frame's config mid-drain
  task automatic run_frame(input int max_gap, input int late_start, input logic do_write,
                           input int wr_len, input branch_mask_t wr_mask);
    int start_count;
    start_count = frames_done;
    push_count  = active_len;
    for (int b = 0; b < NUM_BRANCHES; b++) begin
      for (int i = 0; i < push_count; i++) begin
        model_mem[b][model_tail[b] + i] = $urandom;
        // Branch 0 stays contiguous so the fill trigger comes on time
        if (b == 0) gap[b][i] = 0;
        else gap[b][i] = $urandom_range(max_gap, 0) + ((i == 0) ? late_start : 0);
      end
      model_tail[b] += push_count;
    end
    // Enabled branches ascending with the oldest pixels of each
    for (int b = 0; b < NUM_BRANCHES; b++) begin
      if (active_mask[b]) begin
        for (int i = 0; i < active_len; i++) begin
          exp_q.push_back(model_mem[b][model_head[b]]);
          model_head[b]++;
        end
      end
    end
    fork
      drive_branch(0);
      drive_branch(1);
      drive_branch(2);
      drive_branch(3);
      drive_branch(4);
      begin
        if (do_write) begin
          wait_first_beat();
          write_cfg(ADDR_CHANNEL_LEN, CFG_DATA_WIDTH'(wr_len));
          write_cfg(ADDR_BRANCH_MASK, CFG_DATA_WIDTH'(wr_mask));
        end
      end
    join
    wait_frame_done(start_count);
    assert (exp_q.size() == 0) else
      report_error($sformatf("%0d pixels never came out", exp_q.size()));
    // Snapshot at frame end picks up the staged values
    if (do_write) begin
      active_len  = legal_len(wr_len);
      active_mask = wr_mask;
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin : main_seq
    int mark;
    void'($urandom(RAND_SEED));
    errors       = 0;
    failed_tests = 0;
    tests_run    = 0;
    frames_done  = 0;
    active_len   = FIFO_DEPTH;
    active_mask  = '1;
    for (int b = 0; b < NUM_BRANCHES; b++) begin
      model_head[b] = 0;
      model_tail[b] = 0;
    end
    cfg       = '0;
    branch_in = '0;
    reset     = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    mark = errors;
    repeat (20) begin
      assert (!out_beat.valid && !frame_done) else report_error("output active without input");
      @(posedge clk);
      #1;
    end
    end_test("idle after reset", mark);

    // Reset config gives full depth on all branches
    mark = errors;
    run_frame(0, 0, 1'b0, 0, '0);
    run_frame(0, 0, 1'b1, 8, 5'b11111);
    end_test("two full-depth frames", mark);

    mark = errors;
    run_frame(0, 0, 1'b0, 0, '0);
    end_test("length 8, all branches", mark);

    // Old length 8 holds while 3 is written
    mark = errors;
    run_frame(3, 12, 1'b1, 3, 5'b11111);
    end_test("random gaps, mid-frame write", mark);

    mark = errors;
    run_frame(0, 0, 1'b1, 0, 5'b11111);
    run_frame(0, 0, 1'b1, 8, 5'b10110);
    end_test("length 3 then length 0", mark);

    // Branches 0 and 3 get data that must stay buffered
    mark = errors;
    run_frame(0, 0, 1'b0, 0, '0);
    repeat (20) begin
      @(posedge clk);
      #1;
    end
    end_test("mask 10110", mark);

    $display("Tests: %0d run, %0d with errors, %0d errors in total",
             tests_run, failed_tests, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* logic/channel_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

// Single-clock circular buffer for one branch
module channel_fifo #(
  parameter int DEPTH = concat_pkg::FIFO_DEPTH
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    write,
  input  concat_pkg::pixel_t      data_in,
  input  logic                    read,
  output concat_pkg::pixel_beat_t data_out,
  output logic                    empty,
  output concat_pkg::count_t      level
);

  import concat_pkg::*;

  // Pointers wrap naturally for power-of-two depths
  localparam int PTR_WIDTH = $clog2(DEPTH);

  pixel_t               mem [DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  count_t               fill;
  logic                 rd_fire;
  logic                 rd_valid;
  pixel_t               rd_data;

  // Reads on an empty buffer are dropped
  assign rd_fire = read && (fill != '0);

  //////////////////////////////
  // Pointers and occupancy
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill     <= '0;
      rd_valid <= 1'b0;
    end else begin
      if (write) wr_ptr <= wr_ptr + 1'b1;
      if (rd_fire) rd_ptr <= rd_ptr + 1'b1;
      // Simultaneous push and pop leaves the level alone
      case ({write, rd_fire})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
      // Valid one cycle after an accepted read
      rd_valid <= rd_fire;
    end
  end

  // Storage and registered read port
  always_ff @(posedge clk) begin
    if (write) mem[wr_ptr] <= data_in;
    if (rd_fire) rd_data <= mem[rd_ptr];
  end

  assign data_out = '{valid: rd_valid, data: rd_data};
  assign empty    = (fill == '0);
  assign level    = fill;

endmodule

`default_nettype wire

/* logic/concat_cfg_pkg.sv */
`default_nettype none

// Configuration register map and structs
package concat_cfg_pkg;

  //////////////////////////////
  // Register map
  //////////////////////////////

  localparam int CFG_ADDR_WIDTH = 2;
  localparam int CFG_DATA_WIDTH = 16;

  // Pixels per branch per frame
  localparam logic [CFG_ADDR_WIDTH-1:0] ADDR_CHANNEL_LEN = 2'd0;
  // One enable bit per branch
  localparam logic [CFG_ADDR_WIDTH-1:0] ADDR_BRANCH_MASK = 2'd1;

  // Single-cycle write from the host side
  typedef struct packed {
    logic                      strobe;
    logic [CFG_ADDR_WIDTH-1:0] addr;
    logic [CFG_DATA_WIDTH-1:0] data;
  } cfg_write_t;

  // Decoded configuration as seen by the sequencer
  typedef struct packed {
    concat_pkg::count_t       channel_len;
    concat_pkg::branch_mask_t branch_mask;
  } concat_cfg_t;

endpackage

`default_nettype wire

/* logic/concat_pkg.sv */
`default_nettype none

// Datapath definitions shared by the FIFOs, the sequencer and the top level
package concat_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  // Concat inputs
  localparam int NUM_BRANCHES     = 5;
  localparam int PIXEL_WIDTH      = 32;
  // Per-branch buffer, also the longest channel
  localparam int FIFO_DEPTH       = 64;
  // Holds 0 to FIFO_DEPTH inclusive
  localparam int COUNT_WIDTH      = 7;
  localparam int BRANCH_IDX_WIDTH = 3;

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef logic [PIXEL_WIDTH-1:0]      pixel_t;
  typedef logic [COUNT_WIDTH-1:0]      count_t;
  typedef logic [BRANCH_IDX_WIDTH-1:0] branch_idx_t;
  typedef logic [NUM_BRANCHES-1:0]     branch_mask_t;

  // One pixel with its strobe
  typedef struct packed {
    logic   valid;
    pixel_t data;
  } pixel_beat_t;

  // Sequencer states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_FILL,
    ST_DRAIN,
    ST_NEXT
  } seq_state_t;

endpackage

`default_nettype wire

/* logic/concat_regs.sv */
`timescale 1ns/1ps
`default_nettype none

// Configuration registers for the concat stage
module concat_regs (
  input  logic                       clk,
  input  logic                       reset,
  input  concat_cfg_pkg::cfg_write_t cfg,
  output concat_cfg_pkg::concat_cfg_t cfg_out
);

  import concat_pkg::*;
  import concat_cfg_pkg::*;

  count_t       len_clamped;
  count_t       channel_len;
  branch_mask_t branch_mask;

  //////////////////////////////
  // Length clamp
  //////////////////////////////

  // Legal range is 1 to FIFO_DEPTH
  always_comb begin
    if (cfg.data == '0) begin
      len_clamped = count_t'(1);
    end else if (cfg.data > CFG_DATA_WIDTH'(FIFO_DEPTH)) begin
      len_clamped = count_t'(FIFO_DEPTH);
    end else begin
      len_clamped = cfg.data[COUNT_WIDTH-1:0];
    end
  end

  // Address decode on the write strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      // Full channel, every branch on
      channel_len <= count_t'(FIFO_DEPTH);
      branch_mask <= '1;
    end else if (cfg.strobe) begin
      case (cfg.addr)
        ADDR_CHANNEL_LEN: channel_len <= len_clamped;
        ADDR_BRANCH_MASK: branch_mask <= cfg.data[NUM_BRANCHES-1:0];
        // Unmapped addresses fall through
        default: ;
      endcase
    end
  end

  assign cfg_out = '{channel_len: channel_len, branch_mask: branch_mask};

endmodule

`default_nettype wire

/* logic/concat_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

// Drains the branch FIFOs in ascending order onto one output stream
module concat_sequencer (
  input  logic                                                clk,
  input  logic                                                reset,
  input  concat_cfg_pkg::concat_cfg_t                         cfg_in,
  input  concat_pkg::pixel_beat_t [concat_pkg::NUM_BRANCHES-1:0] fifo_beat,
  input  concat_pkg::branch_mask_t                            fifo_empty,
  input  concat_pkg::count_t                                  first_level,
  output concat_pkg::branch_mask_t                            fifo_read,
  output concat_pkg::pixel_beat_t                             out_beat,
  output logic                                                frame_done
);

  import concat_pkg::*;

  seq_state_t   state;
  // Frame snapshot of the configuration
  count_t       snap_len;
  branch_mask_t snap_mask;
  // Branch being drained, all ones before the first
  branch_idx_t  cur;
  count_t       issued;

  branch_idx_t  search_from;
  branch_idx_t  nxt_idx;
  logic         nxt_found;
  branch_idx_t  sel;
  logic         more_after;
  count_t       cnt_base;
  logic         rd_fire;
  logic         last_of_branch;
  logic         frame_last;
  logic         last_tag_d1;
  pixel_beat_t  merged;
  logic         out_valid;
  pixel_t       out_data;

  //////////////////////////////
  // Branch selection
  //////////////////////////////

  // cur of all ones wraps to zero at frame start
  assign search_from = cur + 1'b1;
  // ST_NEXT reads the newly picked branch in the same cycle
  assign sel      = (state == ST_NEXT) ? nxt_idx : cur;
  assign cnt_base = (state == ST_NEXT) ? '0 : issued;

  always_comb begin
    nxt_found  = 1'b0;
    nxt_idx    = '0;
    more_after = 1'b0;
    // Lowest enabled branch at or above search_from
    for (int k = NUM_BRANCHES - 1; k >= 0; k--) begin
      if (snap_mask[k] && (branch_idx_t'(k) >= search_from)) begin
        nxt_found = 1'b1;
        nxt_idx   = branch_idx_t'(k);
      end
    end
    // Anything left after the selected branch
    for (int k = 0; k < NUM_BRANCHES; k++) begin
      if (snap_mask[k] && (branch_idx_t'(k) > sel)) more_after = 1'b1;
    end
  end

  // Read only while the selected FIFO has data
  assign rd_fire = ((state == ST_DRAIN) || ((state == ST_NEXT) && nxt_found)) &&
                   !fifo_empty[sel];
  assign last_of_branch = rd_fire && (cnt_base == snap_len - 1'b1);
  assign frame_last     = last_of_branch && !more_after;

  always_comb begin
    fifo_read = '0;
    if (rd_fire) fifo_read[sel] = 1'b1;
  end

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ST_IDLE;
      snap_len  <= '0;
      snap_mask <= '0;
      cur       <= '1;
      issued    <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          // Empty mask keeps the stage parked
          if (cfg_in.branch_mask != '0) begin
            snap_len  <= cfg_in.channel_len;
            snap_mask <= cfg_in.branch_mask;
            cur       <= '1;
            state     <= ST_WAIT_FILL;
          end
        end
        ST_WAIT_FILL: begin
          if (first_level >= snap_len) state <= ST_NEXT;
        end
        ST_DRAIN: begin
          issued <= cnt_base + count_t'(rd_fire);
          if (last_of_branch) state <= ST_NEXT;
        end
        ST_NEXT: begin
          if (!nxt_found) begin
            state <= ST_IDLE;
          end else begin
            cur    <= nxt_idx;
            issued <= cnt_base + count_t'(rd_fire);
            // Length of one stays here for the following branch
            if (!last_of_branch) state <= ST_DRAIN;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Output stage
  //////////////////////////////

  // At most one FIFO presents a beat
  always_comb begin
    merged = '0;
    for (int k = 0; k < NUM_BRANCHES; k++) begin
      if (fifo_beat[k].valid) merged = fifo_beat[k];
    end
  end

  // Final-read tag follows the pixel through both stages
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid   <= 1'b0;
      last_tag_d1 <= 1'b0;
      frame_done  <= 1'b0;
    end else begin
      out_valid   <= merged.valid;
      last_tag_d1 <= frame_last;
      frame_done  <= last_tag_d1;
    end
  end

  always_ff @(posedge clk) begin
    if (merged.valid) out_data <= merged.data;
  end

  assign out_beat = '{valid: out_valid, data: out_data};

endmodule

`default_nettype wire

/* logic/concat_unit.sv */
`timescale 1ns/1ps
`default_nettype none

// Channel concatenation stage with five buffered branches
module concat_unit (
  input  logic                                                clk,
  input  logic                                                reset,
  input  concat_cfg_pkg::cfg_write_t                          cfg,
  input  concat_pkg::pixel_beat_t [concat_pkg::NUM_BRANCHES-1:0] branch_in,
  output concat_pkg::pixel_beat_t                             out_beat,
  output logic                                                frame_done
);

  import concat_pkg::*;
  import concat_cfg_pkg::*;

  concat_cfg_t                    cfg_level;
  pixel_beat_t [NUM_BRANCHES-1:0] fifo_beat;
  branch_mask_t                   fifo_empty;
  branch_mask_t                   fifo_read;
  count_t                         fifo_level [NUM_BRANCHES];
  branch_idx_t                    first_idx;
  count_t                         first_level;

  //////////////////////////////
  // Configuration
  //////////////////////////////

  concat_regs regs_inst (
    .clk     (clk),
    .reset   (reset),
    .cfg     (cfg),
    .cfg_out (cfg_level)
  );

  // One buffer per branch
  for (genvar k = 0; k < NUM_BRANCHES; k++) begin : g_branch
    channel_fifo #(
      .DEPTH (FIFO_DEPTH)
    ) fifo_inst (
      .clk      (clk),
      .reset    (reset),
      .write    (branch_in[k].valid),
      .data_in  (branch_in[k].data),
      .read     (fifo_read[k]),
      .data_out (fifo_beat[k]),
      .empty    (fifo_empty[k]),
      .level    (fifo_level[k])
    );
  end

  // Priority encoder for the lowest enabled branch
  always_comb begin
    first_idx = '0;
    for (int k = NUM_BRANCHES - 1; k >= 0; k--) begin
      if (cfg_level.branch_mask[k]) first_idx = branch_idx_t'(k);
    end
  end

  // Fill level that triggers the frame
  assign first_level = fifo_level[first_idx];

  //////////////////////////////
  // Sequencer
  //////////////////////////////

  concat_sequencer sequencer_inst (
    .clk         (clk),
    .reset       (reset),
    .cfg_in      (cfg_level),
    .fifo_beat   (fifo_beat),
    .fifo_empty  (fifo_empty),
    .first_level (first_level),
    .fifo_read   (fifo_read),
    .out_beat    (out_beat),
    .frame_done  (frame_done)
  );

endmodule

`default_nettype wire

/* tb.f */
logic/concat_pkg.sv
logic/concat_cfg_pkg.sv
logic/channel_fifo.sv
logic/concat_regs.sv
logic/concat_sequencer.sv
logic/concat_unit.sv
bench/concat_unit_tb.sv
